// File: source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int xlen         = 32;
  localparam int addr_width   = 32;
  localparam int reg_id_width = 5;
  localparam int reg_count    = 32;
  localparam int shamt_width  = 5;

  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui    = 7'b0110111;

  // code is inst[30] above funct3
  // pass takes a code that no instruction decodes to
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111,
    alu_sub  = 4'b1000,
    alu_sra  = 4'b1101,
    alu_pass = 4'b1111
  } alu_func_t;

  typedef struct packed {
    logic [6:0]              funct7;
    logic [reg_id_width-1:0] rs2;
    logic [reg_id_width-1:0] rs1;
    logic [2:0]              funct3;
    logic [reg_id_width-1:0] rd;
    logic [6:0]              opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]             imm12;
    logic [reg_id_width-1:0] rs1;
    logic [2:0]              funct3;
    logic [reg_id_width-1:0] rd;
    logic [6:0]              opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0]             imm20;
    logic [reg_id_width-1:0] rd;
    logic [6:0]              opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r_view;
    i_fmt_t i_view;
    u_fmt_t u_view;
  } inst_u;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    inst_u           inst;
  } fetch_t;

  typedef struct packed {
    logic                    valid;
    logic [reg_id_width-1:0] rd;
    alu_func_t               func;
    logic [xlen-1:0]         op_a;
    logic [xlen-1:0]         op_b;
    logic [xlen-1:0]         pc;
  } issue_t;

  typedef struct packed {
    logic                    valid;
    logic [reg_id_width-1:0] rd;
    logic [xlen-1:0]         value;
  } commit_t;

endpackage

`default_nettype wire

// File: source/inst_fetcher.sv
`timescale 1ns/1ps
`default_nettype none

module inst_fetcher (
  input  logic                           clk_in,
  input  logic                           rst_in,
  input  logic                           rdy_in,
  input  logic [7:0]                     mem_din,
  input  logic                           issue_stall,
  output logic [cpu_pkg::addr_width-1:0] mem_a,
  output cpu_pkg::fetch_t                fetch
);
  import cpu_pkg::*;

  logic [addr_width-1:0] pc;
  logic [1:0]            cap_cnt;
  logic                  pending;
  logic [2:0][7:0]       asm_bytes;
  logic [2:0]            in_flight;
  logic [2:0]            rd_offset;
  logic                  start_read;
  logic                  last_byte;
  logic                  fetch_valid;
  logic [xlen-1:0]       fetch_pc;
  inst_u                 fetch_inst;

  // bytes captured plus the one still on its way from RAM
  assign in_flight = {1'b0, cap_cnt} + {2'b0, pending};

  // a paused cycle loses the pending byte, so point back at it
  assign rd_offset = {1'b0, cap_cnt} + {2'b0, pending & rdy_in};
  assign mem_a     = pc + addr_width'(rd_offset);

  assign start_read = rdy_in && !issue_stall && (in_flight < 3'd4);
  assign last_byte  = pending && (cap_cnt == 2'd3);

  assign fetch.valid = fetch_valid;
  assign fetch.pc    = fetch_pc;
  assign fetch.inst  = fetch_inst;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pc          <= '0;
      cap_cnt     <= 2'd0;
      pending     <= 1'b0;
      fetch_valid <= 1'b0;
    end else if (!rdy_in) begin
      // byte on mem_din this cycle is dropped and read again
      pending <= 1'b0;
    end else begin
      pending <= start_read;
      if (pending) begin
        if (last_byte) begin
          cap_cnt <= 2'd0;
          pc      <= pc + addr_width'(4);
        end else begin
          cap_cnt <= cap_cnt + 2'd1;
        end
      end
      if (last_byte) begin
        fetch_valid <= 1'b1;
      end else if (!issue_stall) begin
        fetch_valid <= 1'b0;
      end
    end
  end

  // little endian assembly, lowest address first
  always_ff @(posedge clk_in) begin
    if (rdy_in && pending) begin
      if (cap_cnt == 2'd3) begin
        fetch_inst <= {mem_din, asm_bytes};
        fetch_pc   <= pc;
      end else begin
        asm_bytes[cap_cnt] <= mem_din;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/issuer.sv
`timescale 1ns/1ps
`default_nettype none

module issuer (
  input  logic                             clk_in,
  input  logic                             rst_in,
  input  logic                             rdy_in,
  input  cpu_pkg::fetch_t                  fetch,
  output logic                             issue_stall,
  output logic [cpu_pkg::reg_id_width-1:0] rs1_id,
  output logic [cpu_pkg::reg_id_width-1:0] rs2_id,
  input  logic [cpu_pkg::xlen-1:0]         rs1_data,
  input  logic [cpu_pkg::xlen-1:0]         rs2_data,
  input  logic                             rs1_busy,
  input  logic                             rs2_busy,
  output cpu_pkg::commit_t                 set_busy,
  output cpu_pkg::issue_t                  issue
);
  import cpu_pkg::*;

  logic [6:0]              opcode;
  logic [reg_id_width-1:0] rd;
  logic                    is_op;
  logic                    is_op_imm;
  logic                    is_lui;
  logic                    supported;
  logic                    uses_rs1;
  logic                    uses_rs2;
  logic                    alt;
  alu_func_t               func;
  logic [xlen-1:0]         op_a;
  logic [xlen-1:0]         op_b;
  logic                    src_busy;
  logic                    dst_busy;
  logic                    hazard;
  logic                    accept;

  assign opcode    = fetch.inst.r_view.opcode;
  assign rd        = fetch.inst.r_view.rd;
  assign rs1_id    = fetch.inst.r_view.rs1;
  assign rs2_id    = fetch.inst.r_view.rs2;
  assign is_op     = (opcode == opcode_op);
  assign is_op_imm = (opcode == opcode_op_imm);
  assign is_lui    = (opcode == opcode_lui);
  assign supported = is_op || is_op_imm || is_lui;
  assign uses_rs1  = is_op || is_op_imm;
  assign uses_rs2  = is_op;

  always_comb begin
    alt  = 1'b0;
    func = alu_pass;
    op_a = rs1_data;
    op_b = rs2_data;
    if (is_op) begin
      // bit 30 only means sub or sra
      alt  = fetch.inst.r_view.funct7[5] &&
             (fetch.inst.r_view.funct3 == 3'b000 || fetch.inst.r_view.funct3 == 3'b101);
      func = alu_func_t'({alt, fetch.inst.r_view.funct3});
    end else if (is_op_imm) begin
      alt  = fetch.inst.i_view.imm12[10] && (fetch.inst.i_view.funct3 == 3'b101);
      func = alu_func_t'({alt, fetch.inst.i_view.funct3});
      op_b = {{(xlen - 12){fetch.inst.i_view.imm12[11]}}, fetch.inst.i_view.imm12};
    end else if (is_lui) begin
      op_a = '0;
      op_b = {fetch.inst.u_view.imm20, 12'b0};
    end
  end

  // x0 is never busy in the register file
  assign src_busy = (uses_rs1 && rs1_busy) || (uses_rs2 && rs2_busy);

  // destination still owned by the instruction now in exec
  assign dst_busy = issue.valid && (rd != '0) && (issue.rd == rd);

  assign hazard      = supported && (src_busy || dst_busy);
  assign issue_stall = fetch.valid && hazard;
  assign accept      = fetch.valid && !hazard;

  assign set_busy.valid = accept && supported && (rd != '0);
  assign set_busy.rd    = rd;
  assign set_busy.value = '0;

  // unsupported words are consumed here without an issue pulse
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      issue.valid <= 1'b0;
    end else if (rdy_in) begin
      issue.valid <= accept && supported;
      if (accept && supported) begin
        issue.rd   <= rd;
        issue.func <= func;
        issue.op_a <= op_a;
        issue.op_b <= op_b;
        issue.pc   <= fetch.pc;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                             clk_in,
  input  logic                             rst_in,
  input  logic                             rdy_in,
  input  logic [cpu_pkg::reg_id_width-1:0] rs1_id,
  input  logic [cpu_pkg::reg_id_width-1:0] rs2_id,
  output logic [cpu_pkg::xlen-1:0]         rs1_data,
  output logic [cpu_pkg::xlen-1:0]         rs2_data,
  output logic                             rs1_busy,
  output logic                             rs2_busy,
  input  cpu_pkg::commit_t                 set_busy,
  input  cpu_pkg::commit_t                 writeback
);
  import cpu_pkg::*;

  logic [xlen-1:0]      regs [reg_count];
  logic [reg_count-1:0] busy;

  // x0 always reads as zero
  assign rs1_data = (rs1_id == '0) ? '0 : regs[rs1_id];
  assign rs2_data = (rs2_id == '0) ? '0 : regs[rs2_id];

  assign rs1_busy = busy[rs1_id];
  assign rs2_busy = busy[rs2_id];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy <= '0;
    end else if (rdy_in) begin
      if (writeback.valid) begin
        busy[writeback.rd] <= 1'b0;
      end
      // set after clear, so a new reservation wins
      if (set_busy.valid && set_busy.rd != '0) begin
        busy[set_busy.rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in && writeback.valid && writeback.rd != '0) begin
      regs[writeback.rd] <= writeback.value;
    end
  end

endmodule

`default_nettype wire

// File: source/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
  input  logic             clk_in,
  input  logic             rst_in,
  input  logic             rdy_in,
  input  cpu_pkg::issue_t  issue,
  output cpu_pkg::commit_t commit
);
  import cpu_pkg::*;

  logic [shamt_width-1:0] shamt;
  logic [xlen-1:0]        result;

  assign shamt = issue.op_b[shamt_width-1:0];

  always_comb begin
    case (issue.func)
      alu_add:  result = issue.op_a + issue.op_b;
      alu_sub:  result = issue.op_a - issue.op_b;
      alu_sll:  result = issue.op_a << shamt;
      alu_slt:  result = xlen'($signed(issue.op_a) < $signed(issue.op_b));
      alu_sltu: result = xlen'(issue.op_a < issue.op_b);
      alu_xor:  result = issue.op_a ^ issue.op_b;
      alu_srl:  result = issue.op_a >> shamt;
      alu_sra:  result = $unsigned($signed(issue.op_a) >>> shamt);
      alu_or:   result = issue.op_a | issue.op_b;
      alu_and:  result = issue.op_a & issue.op_b;
      alu_pass: result = issue.op_b;
      default:  result = '0;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      commit.valid <= 1'b0;
    end else if (rdy_in) begin
      commit.valid <= issue.valid;
      if (issue.valid) begin
        commit.rd <= issue.rd;
        // writes to x0 retire as zero
        commit.value <= (issue.rd == '0) ? '0 : result;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
  input  logic                           clk_in,
  input  logic                           rst_in,
  input  logic                           rdy_in,
  input  logic [7:0]                     mem_din,
  output logic [cpu_pkg::addr_width-1:0] mem_a,
  output cpu_pkg::commit_t               commit
);
  import cpu_pkg::*;

  fetch_t                  fetch;
  logic                    issue_stall;
  logic [reg_id_width-1:0] rs1_id;
  logic [reg_id_width-1:0] rs2_id;
  logic [xlen-1:0]         rs1_data;
  logic [xlen-1:0]         rs2_data;
  logic                    rs1_busy;
  logic                    rs2_busy;
  commit_t                 set_busy;
  issue_t                  issue;

  inst_fetcher inst_fetcher_0 (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .mem_din     (mem_din),
    .issue_stall (issue_stall),
    .mem_a       (mem_a),
    .fetch       (fetch)
  );

  issuer issuer_0 (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .fetch       (fetch),
    .issue_stall (issue_stall),
    .rs1_id      (rs1_id),
    .rs2_id      (rs2_id),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .rs1_busy    (rs1_busy),
    .rs2_busy    (rs2_busy),
    .set_busy    (set_busy),
    .issue       (issue)
  );

  // commit record doubles as the register write port
  reg_file reg_file_0 (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .rdy_in    (rdy_in),
    .rs1_id    (rs1_id),
    .rs2_id    (rs2_id),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .rs1_busy  (rs1_busy),
    .rs2_busy  (rs2_busy),
    .set_busy  (set_busy),
    .writeback (commit)
  );

  exec_unit exec_unit_0 (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .rdy_in (rdy_in),
    .issue  (issue),
    .commit (commit)
  );

endmodule

`default_nettype wire

// File: tests/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
  input logic                           clk_in,
  input logic                           rst_in,
  input logic                           rdy_in,
  input logic [cpu_pkg::addr_width-1:0] mem_a,
  input cpu_pkg::commit_t               commit
);
  import cpu_pkg::*;

  // nothing retires right after reset
  commit_after_reset: assert property (@(posedge clk_in) rst_in |=> !commit.valid)
    else $error("commit valid in the cycle after reset");

  zero_reg_value: assert property (@(posedge clk_in) disable iff (rst_in)
    (commit.valid && commit.rd == '0) |-> commit.value == '0)
    else $error("commit to x0 carries a nonzero value");

  addr_in_range: assert property (@(posedge clk_in) disable iff (rst_in)
    mem_a < 32'h20000)
    else $error("mem_a outside the 128 KB RAM");

  // two paused cycles in a row keep the address
  addr_held_in_pause: assert property (@(posedge clk_in) disable iff (rst_in)
    (!rdy_in && $past(!rdy_in)) |-> $stable(mem_a))
    else $error("mem_a changed while rdy_in was low");

endmodule

bind cpu cpu_checker cpu_checker_0 (.*);

`default_nettype wire

// File: tests/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
  import cpu_pkg::*;

  logic                  clk_in;
  logic                  rst_in;
  logic                  rdy_in;
  logic [7:0]            mem_din;
  logic [addr_width-1:0] mem_a;
  commit_t               commit;

  logic [7:0]            ram [131072];
  logic [addr_width-1:0] ram_addr;
  logic [31:0]           prog [$];
  commit_t               exp_q [$];
  int                    exp_idx;
  int                    commit_count;
  logic                  random_on;

  cpu UUT (
    .clk_in  (clk_in),
    .rst_in  (rst_in),
    .rdy_in  (rdy_in),
    .mem_din (mem_din),
    .mem_a   (mem_a),
    .commit  (commit)
  );

  always #10 clk_in = ~clk_in;

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opcode_op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, opcode_op_imm};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, opcode_lui};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    case (f3)
      3'd0:    res = alt ? a - b : a + b;
      3'd1:    res = a << b[4:0];
      3'd2:    res = {31'b0, $signed(a) < $signed(b)};
      3'd3:    res = {31'b0, a < b};
      3'd4:    res = a ^ b;
      3'd5:    res = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  // expected commit of one word
  // valid stays low when nothing retires
  function automatic commit_t ref_exec(input logic [31:0] w, input logic [31:0] regs [32]);
    commit_t     r;
    logic [31:0] res;
    r   = '0;
    res = '0;
    case (w[6:0])
      opcode_op: begin
        r.valid = 1'b1;
        res = alu_ref(w[14:12], w[30] && (w[14:12] == 3'd0 || w[14:12] == 3'd5),
                      regs[w[19:15]], regs[w[24:20]]);
      end
      opcode_op_imm: begin
        r.valid = 1'b1;
        res = alu_ref(w[14:12], w[30] && (w[14:12] == 3'd5), regs[w[19:15]],
                      {{20{w[31]}}, w[31:20]});
      end
      opcode_lui: begin
        r.valid = 1'b1;
        res = {w[31:12], 12'b0};
      end
      default: r.valid = 1'b0;
    endcase
    r.rd    = w[11:7];
    r.value = (w[11:7] == 5'd0) ? 32'd0 : res;
    return r;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic build_program();
    logic [31:0] w;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] shadow [32];
    commit_t     r;
    // chains, every ALU function, x0 handling and one store
    prog.push_back(enc_i(12'hffb, 5'd0, 3'd0, 5'd1));
    prog.push_back(enc_i(12'd100, 5'd1, 3'd0, 5'd2));
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
    prog.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd4));
    prog.push_back(enc_u(20'hf0000, 5'd5));
    prog.push_back(enc_i(12'd4, 5'd0, 3'd0, 5'd7));
    prog.push_back(enc_r(7'h20, 5'd7, 5'd5, 3'd5, 5'd6));
    prog.push_back(enc_r(7'h00, 5'd7, 5'd5, 3'd5, 5'd8));
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd9));
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd10));
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd12));
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd13));
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd14));
    prog.push_back(enc_r(7'h00, 5'd7, 5'd1, 3'd1, 5'd15));
    prog.push_back(enc_i(12'd3, 5'd1, 3'd1, 5'd16));
    prog.push_back(enc_i(12'd8, 5'd5, 3'd5, 5'd17));
    prog.push_back(enc_i(12'h408, 5'd5, 3'd5, 5'd18));
    prog.push_back(enc_i(12'hfff, 5'd1, 3'd2, 5'd19));
    prog.push_back(enc_i(12'hfff, 5'd1, 3'd3, 5'd20));
    prog.push_back(enc_i(12'h055, 5'd2, 3'd4, 5'd21));
    prog.push_back(enc_i(12'h100, 5'd1, 3'd6, 5'd22));
    prog.push_back(enc_i(12'h7ff, 5'd5, 3'd7, 5'd23));
    prog.push_back(enc_i(12'd7, 5'd1, 3'd0, 5'd0));
    prog.push_back(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd11));
    // sw x2, 0(x1)
    prog.push_back({7'd0, 5'd2, 5'd1, 3'b010, 5'd0, 7'b0100011});
    prog.push_back(enc_r(7'h00, 5'd3, 5'd11, 3'd0, 5'd24));
    // registers the list above leaves unwritten get a known value
    for (int i = 25; i < 32; i++) begin
      prog.push_back(enc_i(12'(i), 5'd0, 3'd0, 5'(i)));
    end
    for (int i = 0; i < 200; i++) begin
      f3  = 3'($urandom_range(7, 0));
      rd  = 5'($urandom_range(31, 0));
      rs1 = 5'($urandom_range(31, 0));
      rs2 = 5'($urandom_range(31, 0));
      case ($urandom_range(2, 0))
        0: w = enc_r(((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(1, 0) == 1) ? 7'h20 : 7'h00,
                     rs2, rs1, f3, rd);
        1: begin
          if (f3 == 3'd1) begin
            w = enc_i({7'h00, rs2}, rs1, f3, rd);
          end else if (f3 == 3'd5) begin
            w = enc_i({($urandom_range(1, 0) == 1) ? 7'h20 : 7'h00, rs2}, rs1, f3, rd);
          end else begin
            w = enc_i(12'($urandom), rs1, f3, rd);
          end
        end
        default: w = enc_u(20'($urandom), rd);
      endcase
      prog.push_back(w);
    end
    for (int i = 0; i < 32768; i++) begin
      w = (i < prog.size()) ? prog[i] : 32'h00000013;
      for (int k = 0; k < 4; k++) begin
        ram[4 * i + k] = w[8 * k +: 8];
      end
    end
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    // filler words retire too
    for (int i = 0; i < prog.size() + 50; i++) begin
      w = (i < prog.size()) ? prog[i] : 32'h00000013;
      r = ref_exec(w, shadow);
      if (r.valid) begin
        exp_q.push_back(r);
        if (r.rd != 5'd0) begin
          shadow[r.rd] = r.value;
        end
      end
    end
  endtask

  // RAM answers one cycle after it sees the address
  always @(posedge clk_in) begin
    ram_addr <= mem_a;
    #2;
    mem_din = ram[ram_addr[16:0]];
    if (random_on) begin
      rdy_in = ($urandom_range(4, 0) != 0);
    end
  end

  always @(posedge clk_in) begin
    if (!rst_in && rdy_in && commit.valid) begin
      if (exp_idx >= exp_q.size()) begin
        abort_run("commit beyond the expected stream");
      end
      check_eq({27'b0, commit.rd}, {27'b0, exp_q[exp_idx].rd}, "commit rd");
      check_eq(commit.value, exp_q[exp_idx].value, "commit value");
      exp_idx++;
      commit_count++;
    end
  end

  initial begin
    int idle;
    void'($urandom(92));
    clk_in       = 1'b0;
    rst_in       = 1'b1;
    rdy_in       = 1'b1;
    mem_din      = 8'd0;
    random_on    = 1'b0;
    exp_idx      = 0;
    commit_count = 0;
    build_program();
    repeat (8) @(posedge clk_in);
    #2;
    rst_in = 1'b0;
    #1;
    // first fetch with no pause walks bytes 0 to 3
    for (int k = 0; k < 4; k++) begin
      check_eq(mem_a, 32'(k), "fetch byte address");
      @(posedge clk_in);
      #3;
    end
    random_on = 1'b1;
    while (commit_count < 200) begin
      idle = commit_count;
      for (int c = 0; c < 200 && commit_count == idle; c++) begin
        @(posedge clk_in);
        #1;
      end
      if (commit_count == idle) begin
        abort_run("no commit within timeout");
      end
    end
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
source/cpu_pkg.sv
source/inst_fetcher.sv
source/issuer.sv
source/reg_file.sv
source/exec_unit.sv
source/cpu.sv
tests/cpu_checker.sv
tests/tb_cpu.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_cpu -o sim_cpu
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_cpu > sim.log 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "All checks passed" sim.log; then
  echo "PASS"
  exit 0
fi

echo "FAIL, see sim.log"
exit 1
